//--- move_sort_top.f
+incdir+source
source/move_types_pkg.sv
source/sort_ctrl_pkg.sv
source/move_store.sv
source/sort_key_table.sv
source/sort_control.sv
source/reorder_writer.sv
source/move_sort_top.sv
dv/move_sort_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the move sorter testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
   --top-module move_sort_tb \
   -f move_sort_top.f \
   -o move_sort_sim

./obj_dir/move_sort_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi

echo "simulation finished without failures"

//--- dv/move_sort_tb.sv
//----------------------------------------
// directed testbench for the move sorter
// writes move lists, sorts, checks bus lines
//----------------------------------------
`default_nettype none

`include "move_sort_params.svh"

module move_sort_tb;
   timeunit 1ns;
   timeprecision 1ps;

   import move_types_pkg::*;
   import sort_ctrl_pkg::*;

   localparam int TIMEOUT_CYCLES = 20 * (16 + 40 + 30) * 2;
   localparam int RUN_LIMIT = 200;  // cycles allowed for one sort

   logic         clk;
   logic         reset;
   logic         evaluate_go;
   logic         sort_start;
   logic         sort_clear;
   logic         white_to_move;
   logic         ram_wr_addr_init;
   logic         ram_wr;
   move_record_t ram_wr_data;
   move_index_t  ram_rd_addr;
   move_record_t ram_rd_data;
   move_index_t  ram_wr_addr;
   line_addr_t   bus_addr;
   line_data_t   bus_din;
   byte_we_t     bus_we;
   logic         sort_complete;

   move_record_t moves [`MAX_POSITIONS];
   int           order [`MAX_POSITIONS];  // expected output order
   int           move_count;
   line_addr_t   line_addr_q [$];
   line_data_t   line_data_q [$];
   int           burst_count = 0;
   logic         we_seen = 1'b0;
   string        test_name = "reset";
   int           cycle_count = 0;
   int           check_count = 0;
   int           error_count = 0;
   int           test_count = 0;
   int           failed_tests = 0;
   int           test_errors = 0;

   move_sort_top move_sort_top_inst
   (
      .clk              (clk),
      .reset            (reset),
      .evaluate_go      (evaluate_go),
      .sort_start       (sort_start),
      .sort_clear       (sort_clear),
      .white_to_move    (white_to_move),
      .ram_wr_addr_init (ram_wr_addr_init),
      .ram_wr           (ram_wr),
      .ram_wr_data      (ram_wr_data),
      .ram_rd_addr      (ram_rd_addr),
      .ram_rd_data      (ram_rd_data),
      .ram_wr_addr      (ram_wr_addr),
      .bus_addr         (bus_addr),
      .bus_din          (bus_din),
      .bus_we           (bus_we),
      .sort_complete    (sort_complete)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("timeout, run stopped after %0d cycles in test %s", cycle_count, test_name);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // bus monitor sampled mid cycle
   always @(negedge clk)
   begin
      if (!reset && bus_we != '0)
      begin
         if (bus_we != '1)
         begin
            $display("%s: bus_we only partly set (%b)", test_name, bus_we);
            error_count++;
         end
         line_addr_q.push_back(bus_addr);
         line_data_q.push_back(bus_din);
         if (!we_seen)
            burst_count++;  // start of a new run of lines
      end
      we_seen = !reset && (bus_we != '0);
   end

   task automatic check_record(input string what, input move_record_t expected,
                               input move_record_t actual);
      check_count++;
      if (actual !== expected)
      begin
         $display("mismatch %s %s: expected %h, actual %h", test_name, what, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_index(input string what, input move_index_t expected,
                              input move_index_t actual);
      check_count++;
      if (actual !== expected)
      begin
         $display("mismatch %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
         error_count++;
      end
   endtask

   task automatic check_line(input string what, input line_addr_t exp_addr,
                             input line_data_t exp_data, input line_addr_t act_addr,
                             input line_data_t act_data);
      check_count++;
      if (act_addr !== exp_addr || act_data !== exp_data)
      begin
         $display("mismatch %s %s: expected %h @ %0d, actual %h @ %0d",
                  test_name, what, exp_data, exp_addr, act_data, act_addr);
         error_count++;
      end
   endtask

   task automatic check_flag(input string what, input logic expected, input logic actual);
      check_count++;
      if (actual !== expected)
      begin
         $display("mismatch %s %s: expected %b, actual %b", test_name, what, expected, actual);
         error_count++;
      end
   endtask

   // side to move decides the sign
   function automatic int move_key(input move_record_t rec, input logic white);
      int value;
      value = int'($signed(rec[`EVAL_WIDTH - 1:0]));
      return white ? value : -value;
   endfunction

   function automatic logic goes_before(input move_record_t a, input move_record_t b,
                                        input logic white);
      if (a[`PV_BIT] != b[`PV_BIT])
         return a[`PV_BIT];
      return move_key(a, white) > move_key(b, white);  // strict, so ties stay put
   endfunction

   // stable insertion sort of the written list
   task automatic build_order(input logic white);
      int j;
      int t;
      for (int i = 0; i < move_count; i++)
         order[i] = i;
      for (int i = 1; i < move_count; i++)
      begin
         j = i;
         while (j > 0 && goes_before(moves[order[j]], moves[order[j - 1]], white))
         begin
            t = order[j];
            order[j] = order[j - 1];
            order[j - 1] = t;
            j--;
         end
      end
   endtask

   function automatic move_record_t make_record(input int value, input logic pv);
      move_record_t rec;
      rec = move_record_t'($urandom);  // random move bits around the key
      rec[`EVAL_WIDTH - 1:0] = value[`EVAL_WIDTH - 1:0];
      rec[`PV_BIT] = pv;
      return rec;
   endfunction

   task automatic write_moves();
      ram_wr_addr_init = 1'b1;
      @(negedge clk);
      ram_wr_addr_init = 1'b0;
      check_index("pointer after init", '0, ram_wr_addr);
      for (int i = 0; i < move_count; i++)
      begin
         ram_wr = 1'b1;
         ram_wr_data = moves[i];
         @(negedge clk);
         check_index("pointer after write", move_index_t'(i + 1), ram_wr_addr);
      end
      ram_wr = 1'b0;
   endtask

   task automatic read_back(input string when);
      for (int i = 0; i < move_count; i++)
      begin
         ram_rd_addr = move_index_t'(i);
         @(negedge clk);
         check_record({"read back ", when}, moves[i], ram_rd_data);
      end
   endtask

   task automatic check_lines(input logic white);
      build_order(white);
      if (line_addr_q.size() != move_count || burst_count != 1)
      begin
         $display("%s: expected %0d lines in one burst, got %0d lines in %0d bursts",
                  test_name, move_count, line_addr_q.size(), burst_count);
         error_count++;
      end
      for (int i = 0; i < move_count && i < line_addr_q.size(); i++)
      begin
         check_line($sformatf("line %0d", i), line_addr_t'(i * `LINE_BYTES),
                    line_data_t'(moves[order[i]]), line_addr_q[i], line_data_q[i]);
      end
   endtask

   // fill, sort, collect the lines, clear
   task automatic run_sort(input logic white);
      int waited;
      white_to_move = white;
      evaluate_go = 1'b1;
      @(negedge clk);
      evaluate_go = 1'b0;
      write_moves();
      read_back("before sort");
      line_addr_q.delete();
      line_data_q.delete();
      burst_count = 0;
      sort_start = 1'b1;
      @(negedge clk);
      sort_start = 1'b0;
      waited = 0;
      while (!sort_complete && waited < RUN_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      if (!sort_complete)
      begin
         $display("%s: sort_complete did not rise within %0d cycles", test_name, RUN_LIMIT);
         error_count++;
      end
      else if (line_addr_q.size() != move_count)
      begin
         $display("%s: sort_complete rose with %0d of %0d lines written",
                  test_name, line_addr_q.size(), move_count);
         error_count++;
      end
      repeat (2) @(negedge clk);  // no stray lines after completion
      check_lines(white);
      read_back("after sort");
      check_flag("sort_complete held", 1'b1, sort_complete);
      sort_clear = 1'b1;
      @(negedge clk);
      sort_clear = 1'b0;
      @(negedge clk);
      check_flag("sort_complete after clear", 1'b0, sort_complete);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errors = error_count;
   endtask

   task automatic finish_test();
      test_count++;
      if (error_count == test_errors)
      begin
         $display("test %s: ok", test_name);
      end
      else
      begin
         failed_tests++;
         $display("test %s: failed with %0d errors", test_name, error_count - test_errors);
      end
   endtask

   task automatic reset_state_test();
      start_test("reset_state");
      check_flag("bus_we after reset", 1'b0, |bus_we);
      check_flag("sort_complete after reset", 1'b0, sort_complete);
      move_count = 3;
      for (int i = 0; i < move_count; i++)
         moves[i] = make_record(100 * i, 1'b0);
      write_moves();
      read_back("in idle");
      finish_test();
   endtask

   task automatic random_white_test();
      start_test("random_white");
      move_count = 10;
      for (int i = 0; i < move_count; i++)
         moves[i] = make_record(int'($urandom_range(40000)) - 20000, 1'b0);
      run_sort(1'b1);
      finish_test();
   endtask

   task automatic random_black_test();
      start_test("random_black");
      run_sort(1'b0);  // same list as before
      finish_test();
   endtask

   task automatic pv_and_ties_test();
      int evals [8];
      start_test("pv_and_ties");
      evals = '{500, 300, 300, -1500, 300, 800, -1500, 500};
      move_count = 8;
      for (int i = 0; i < move_count; i++)
         moves[i] = make_record(evals[i], i == 3);  // low eval but pv
      run_sort(1'b1);
      finish_test();
   endtask

   task automatic worst_case_test();
      start_test("ascending_16");
      move_count = `MAX_POSITIONS;
      for (int i = 0; i < move_count; i++)
         moves[i] = make_record(1000 * i - 7500, 1'b0);
      run_sort(1'b1);
      finish_test();
   endtask

   task automatic single_entry_test();
      start_test("single_entry");
      move_count = 1;
      moves[0] = make_record(-42, 1'b1);
      run_sort(1'b0);
      finish_test();
   endtask

   initial
   begin
      void'($urandom(32'h5e73_a868));
      reset = 1'b1;
      evaluate_go = 1'b0;
      sort_start = 1'b0;
      sort_clear = 1'b0;
      white_to_move = 1'b1;
      ram_wr_addr_init = 1'b0;
      ram_wr = 1'b0;
      ram_wr_data = '0;
      ram_rd_addr = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);

      reset_state_test();
      random_white_test();
      random_black_test();
      pv_and_ties_test();
      worst_case_test();
      single_entry_test();
      single_entry_test();  // second run after clear

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               test_count, failed_tests, check_count, error_count);
      if (error_count == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- source/move_sort_top.sv
//----------------------------------------
// move ordering block, top level
// write moves, sort, stream lines to memory
//----------------------------------------
`default_nettype none

module move_sort_top
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         evaluate_go,
   input  logic                         sort_start,
   input  logic                         sort_clear,
   input  logic                         white_to_move,
   input  logic                         ram_wr_addr_init,
   input  logic                         ram_wr,
   input  move_types_pkg::move_record_t ram_wr_data,
   input  move_types_pkg::move_index_t  ram_rd_addr,
   output move_types_pkg::move_record_t ram_rd_data,
   output move_types_pkg::move_index_t  ram_wr_addr,
   output sort_ctrl_pkg::line_addr_t    bus_addr,
   output sort_ctrl_pkg::line_data_t    bus_din,
   output sort_ctrl_pkg::byte_we_t      bus_we,
   output logic                         sort_complete
);
   import move_types_pkg::*;

   logic         table_init;
   logic         fill_en;
   logic         pass_even;
   logic         pass_odd;
   logic         sorted_even;
   logic         sorted_odd;
   logic         reorder_en;
   move_index_t  reorder_index;
   move_index_t  sorted_addr;
   move_record_t sorted_record;

   move_store move_store_inst
   (
      .clk              (clk),
      .reset            (reset),
      .ram_wr_addr_init (ram_wr_addr_init),
      .ram_wr           (ram_wr),
      .ram_wr_data      (ram_wr_data),
      .ram_rd_addr      (ram_rd_addr),
      .ram_rd_data      (ram_rd_data),
      .ram_wr_addr      (ram_wr_addr),
      .sorted_addr      (sorted_addr),
      .sorted_record    (sorted_record)
   );

   sort_key_table sort_key_table_inst
   (
      .clk           (clk),
      .table_init    (table_init),
      .fill_en       (fill_en),
      .ram_wr        (ram_wr),
      .ram_wr_addr   (ram_wr_addr),
      .ram_wr_data   (ram_wr_data),
      .white_to_move (white_to_move),
      .pass_even     (pass_even),
      .pass_odd      (pass_odd),
      .sorted_even   (sorted_even),
      .sorted_odd    (sorted_odd),
      .reorder_index (reorder_index),
      .sorted_addr   (sorted_addr)
   );

   sort_control sort_control_inst
   (
      .clk           (clk),
      .reset         (reset),
      .evaluate_go   (evaluate_go),
      .sort_start    (sort_start),
      .sort_clear    (sort_clear),
      .ram_wr_addr   (ram_wr_addr),
      .sorted_even   (sorted_even),
      .sorted_odd    (sorted_odd),
      .table_init    (table_init),
      .fill_en       (fill_en),
      .pass_even     (pass_even),
      .pass_odd      (pass_odd),
      .reorder_en    (reorder_en),
      .reorder_index (reorder_index),
      .sort_complete (sort_complete)
   );

   reorder_writer reorder_writer_inst
   (
      .clk           (clk),
      .reset         (reset),
      .reorder_en    (reorder_en),
      .sorted_record (sorted_record),
      .bus_addr      (bus_addr),
      .bus_din       (bus_din),
      .bus_we        (bus_we)
   );

endmodule

`default_nettype wire

//--- source/reorder_writer.sv
//----------------------------------------
// turns sorted records into line writes
// one line per cycle from address 0
//----------------------------------------
`default_nettype none

`include "move_sort_params.svh"

module reorder_writer
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         reorder_en,
   input  move_types_pkg::move_record_t sorted_record,
   output sort_ctrl_pkg::line_addr_t    bus_addr,
   output sort_ctrl_pkg::line_data_t    bus_din,
   output sort_ctrl_pkg::byte_we_t      bus_we
);
   import sort_ctrl_pkg::*;

   logic       en_key;     // lines up with sorted_addr
   logic       en_rec;     // lines up with sorted_record
   line_addr_t next_addr;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         en_key <= 1'b0;
         en_rec <= 1'b0;
         next_addr <= '0;
         bus_we <= '0;
      end
      else
      begin
         en_key <= reorder_en;
         en_rec <= en_key;
         bus_we <= {`LINE_BYTES{en_rec}};
         // restart at 0 between runs
         if (en_rec)
            next_addr <= next_addr + `LINE_BYTES;
         else
            next_addr <= '0;
      end
   end

   always_ff @(posedge clk)
   begin
      bus_addr <= next_addr;
      bus_din <= line_data_t'(sorted_record);  // record in the low bytes
   end

endmodule

`default_nettype wire

//--- source/sort_control.sv
//----------------------------------------
// sequencer for fill, sort passes,
// reorder and completion
//----------------------------------------
`default_nettype none

module sort_control
(
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        evaluate_go,
   input  logic                        sort_start,
   input  logic                        sort_clear,
   input  move_types_pkg::move_index_t ram_wr_addr,
   input  logic                        sorted_even,
   input  logic                        sorted_odd,
   output logic                        table_init,
   output logic                        fill_en,
   output logic                        pass_even,
   output logic                        pass_odd,
   output logic                        reorder_en,
   output move_types_pkg::move_index_t reorder_index,
   output logic                        sort_complete
);
   import move_types_pkg::*;
   import sort_ctrl_pkg::*;

   localparam int WRITER_LATENCY = 3;  // key lookup, record read, bus register

   sort_state_t state;
   move_index_t entry_count;
   move_index_t last_index;
   logic [1:0]  drain_count;

   assign last_index = entry_count - 1'b1;  // 16 entries wrap to 15

   assign table_init = (state == idle);
   assign fill_en = (state == table_fill);
   assign pass_even = (state == sort_even);
   assign pass_odd = (state == sort_odd);
   assign reorder_en = (state == reorder);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= idle;
         reorder_index <= '0;
         drain_count <= '0;
         sort_complete <= 1'b0;
      end
      else
      begin
         case (state)
            idle:
            begin
               reorder_index <= '0;
               drain_count <= '0;
               sort_complete <= 1'b0;
               if (evaluate_go)
                  state <= table_fill;
            end
            table_fill:
            begin
               if (sort_start)
               begin
                  entry_count <= ram_wr_addr;
                  state <= sort_even;
               end
            end
            // both flags set means two quiet passes in a row
            sort_even:
               state <= (sorted_even && sorted_odd) ? reorder : sort_odd;
            sort_odd:
               state <= (sorted_even && sorted_odd) ? reorder : sort_even;
            reorder:
            begin
               reorder_index <= reorder_index + 1'b1;
               if (reorder_index == last_index)
                  state <= done;
            end
            done:
            begin
               if (drain_count == 2'(WRITER_LATENCY - 1))
                  sort_complete <= 1'b1;  // last line is out
               else
                  drain_count <= drain_count + 1'b1;
               if (sort_clear)
                  state <= idle;
            end
            default:
               state <= idle;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/sort_key_table.sv
//----------------------------------------
// key, pv and address tables with the odd-even
// transposition passes; moves are written after evaluate_go
//----------------------------------------
`default_nettype none

`include "move_sort_params.svh"

module sort_key_table
(
   input  logic                         clk,
   input  logic                         table_init,
   input  logic                         fill_en,
   input  logic                         ram_wr,
   input  move_types_pkg::move_index_t  ram_wr_addr,
   input  move_types_pkg::move_record_t ram_wr_data,
   input  logic                         white_to_move,
   input  logic                         pass_even,
   input  logic                         pass_odd,
   output logic                         sorted_even,
   output logic                         sorted_odd,
   input  move_types_pkg::move_index_t  reorder_index,
   output move_types_pkg::move_index_t  sorted_addr
);
   import move_types_pkg::*;

   eval_t                        key_table [`MAX_POSITIONS];
   logic [`MAX_POSITIONS - 1:0]  pv_table;
   move_index_t                  addr_table [`MAX_POSITIONS];
   logic [`MAX_POSITIONS - 2:0]  swap;      // one bit per neighbour pair
   eval_t                        fill_key;

   // lower slot loses to a pv move or to a strictly higher key
   function automatic logic must_swap(input logic pv_lo, input eval_t key_lo,
                                      input logic pv_hi, input eval_t key_hi);
      if (pv_lo != pv_hi)
         return pv_hi;
      return key_lo < key_hi;
   endfunction

   assign fill_key = white_to_move ? record_eval(ram_wr_data) : -record_eval(ram_wr_data);

   always_comb
   begin
      for (int i = 0; i < `MAX_POSITIONS - 1; i++)
      begin
         swap[i] = ((i % 2 == 0) ? pass_even : pass_odd) &&
                   must_swap(pv_table[i], key_table[i], pv_table[i + 1], key_table[i + 1]);
      end
   end

   always_ff @(posedge clk)
   begin
      if (table_init)
      begin
         for (int i = 0; i < `MAX_POSITIONS; i++)
         begin
            key_table[i] <= eval_t'(`BAD_EVAL);
            pv_table[i] <= 1'b0;
            addr_table[i] <= move_index_t'(i);
         end
         sorted_even <= 1'b0;
         sorted_odd <= 1'b0;
      end
      else if (fill_en)
      begin
         if (ram_wr)
         begin
            key_table[ram_wr_addr] <= fill_key;
            pv_table[ram_wr_addr] <= record_pv(ram_wr_data);
         end
      end
      else
      begin
         // pairs of one pass never overlap
         for (int i = 0; i < `MAX_POSITIONS - 1; i++)
         begin
            if (swap[i])
            begin
               key_table[i] <= key_table[i + 1];
               key_table[i + 1] <= key_table[i];
               pv_table[i] <= pv_table[i + 1];
               pv_table[i + 1] <= pv_table[i];
               addr_table[i] <= addr_table[i + 1];
               addr_table[i + 1] <= addr_table[i];
            end
         end
         if (pass_even)
            sorted_even <= ~|swap;
         if (pass_odd)
            sorted_odd <= ~|swap;
      end
   end

   always_ff @(posedge clk)
   begin
      sorted_addr <= addr_table[reorder_index];  // original record address
   end

endmodule

`default_nettype wire

//--- source/move_store.sv
//----------------------------------------
// move record RAM with write pointer
// host read port and sorted read port
//----------------------------------------
`default_nettype none

`include "move_sort_params.svh"

module move_store
(
   input  logic                         clk,
   input  logic                         reset,
   input  logic                         ram_wr_addr_init,
   input  logic                         ram_wr,
   input  move_types_pkg::move_record_t ram_wr_data,
   input  move_types_pkg::move_index_t  ram_rd_addr,
   output move_types_pkg::move_record_t ram_rd_data,
   output move_types_pkg::move_index_t  ram_wr_addr,
   input  move_types_pkg::move_index_t  sorted_addr,
   output move_types_pkg::move_record_t sorted_record
);
   import move_types_pkg::*;

   move_record_t ram [`MAX_POSITIONS];

   // write pointer, a write beats init
   always_ff @(posedge clk)
   begin
      if (reset)
         ram_wr_addr <= '0;
      else if (ram_wr)
         ram_wr_addr <= ram_wr_addr + 1'b1;
      else if (ram_wr_addr_init)
         ram_wr_addr <= '0;
   end

   always_ff @(posedge clk)
   begin
      if (ram_wr)
         ram[ram_wr_addr] <= ram_wr_data;
   end

   always_ff @(posedge clk)
   begin
      ram_rd_data <= ram[ram_rd_addr];     // host side
      sorted_record <= ram[sorted_addr];   // reorder side
   end

endmodule

`default_nettype wire

//--- source/sort_ctrl_pkg.sv
//----------------------------------------
// controller states and memory bus types
//----------------------------------------
`default_nettype none

`include "move_sort_params.svh"

package sort_ctrl_pkg;

   typedef enum logic [2:0] {
      idle,
      table_fill,
      sort_even,
      sort_odd,
      reorder,
      done
   } sort_state_t;

   typedef logic [31:0] line_addr_t;  // byte address
   typedef logic [`LINE_BYTES * 8 - 1:0] line_data_t;
   typedef logic [`LINE_BYTES - 1:0] byte_we_t;

endpackage

`default_nettype wire

//--- source/move_types_pkg.sv
//----------------------------------------
// move record and sort key types
//----------------------------------------
`default_nettype none

`include "move_sort_params.svh"

package move_types_pkg;

   typedef logic [`RECORD_WIDTH - 1:0] move_record_t;
   typedef logic signed [`EVAL_WIDTH - 1:0] eval_t;
   typedef logic [`MAX_POSITIONS_LOG2 - 1:0] move_index_t;

   function automatic eval_t record_eval(input move_record_t rec);
      return eval_t'(rec[`EVAL_WIDTH - 1:0]);
   endfunction

   function automatic logic record_pv(input move_record_t rec);
      return rec[`PV_BIT];
   endfunction

endpackage

`default_nettype wire

//--- source/move_sort_params.svh
//----------------------------------------
// sizes and constants of the move sorter
// include wherever a width is needed
//----------------------------------------
`ifndef MOVE_SORT_PARAMS_SVH
`define MOVE_SORT_PARAMS_SVH

`define MAX_POSITIONS 16
`define MAX_POSITIONS_LOG2 4

`define EVAL_WIDTH 16
`define RECORD_WIDTH 32
`define PV_BIT (`EVAL_WIDTH + 3)  // pv flag sits above the eval field

`define LINE_BYTES 8

`define GLOBAL_VALUE_KING 20000
`define BAD_EVAL (-(`GLOBAL_VALUE_KING + 500))  // below any real eval

`endif
